// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_hps_io
FILELIST = sources.f
OBJ_DIR  = obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with $(SIM) and run $(TOP)"
	@echo "  clean  remove the build directory"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "No errors"

clean:
	rm -rf $(OBJ_DIR)

// File: bench/tb_hps_io.sv
// testbench for hps_io: clock, reset, LFSR, host frame task, model, compare tasks, PS/2 decoder

`timescale 1ns/10ps
`default_nettype none

`include "hps_defines.svh"

module tb_hps_io;

	localparam int N_REG_FRAMES    = 24;
	localparam int N_STATUS_PULSES = 4;
	localparam int N_DAT_FRAMES    = 2;
	localparam int DAT_BYTES       = 6;
	localparam int N_KBD_FRAMES    = 4;
	localparam int KBD_WORDS       = 4;
	localparam int N_FRAMES = N_REG_FRAMES + 2 + N_STATUS_PULSES + 4 + N_DAT_FRAMES
		+ N_KBD_FRAMES;
	// start, 8 data, parity, stop, plus the idle rise and one period of pickup delay
	localparam int BYTE_CYCLES = 13 * 2 * `HPS_PS2_DIV;
	localparam int CYCLE_LIMIT = 8 + 40 * N_FRAMES + N_KBD_FRAMES * KBD_WORDS * BYTE_CYCLES;

	logic                         clk_sys = 1'b0;
	logic                         arst_n;
	logic                         io_enable;
	logic                         io_strobe;
	hps_cmd_pkg::io_word_t        io_din;
	hps_cmd_pkg::io_word_t        io_dout;
	logic                         io_wait;
	logic [8*`HPS_STRLEN-1:0]     conf_str;
	logic [1:0]                   buttons;
	logic                         forced_scandoubler;
	hps_user_pkg::joystick_t      joystick_0;
	hps_user_pkg::joystick_t      joystick_1;
	hps_user_pkg::status_t        status;
	hps_user_pkg::status_t        status_in;
	logic                         status_set;
	logic                         ioctl_download;
	logic [7:0]                   ioctl_index;
	logic                         ioctl_wr;
	hps_user_pkg::ioctl_addr_t    ioctl_addr;
	hps_user_pkg::ioctl_byte_t    ioctl_dout;
	hps_user_pkg::file_ext_t      ioctl_file_ext;
	logic                         ioctl_wait;
	logic                         ps2_kbd_clk_out;
	logic                         ps2_kbd_data_out;

	// host side buffers, reply_buf[k] is the answer to strobe k
	hps_cmd_pkg::io_word_t        data_buf [1:16];
	hps_cmd_pkg::io_word_t        reply_buf [0:16];
	logic [31:0]                  lfsr = 32'hafdf;
	int                           cycles = 0;

	// model state
	logic [7:0]                   str_bytes [1:`HPS_STRLEN];
	logic [1:0]                   exp_buttons = '0;
	logic                         exp_sd = 1'b0;
	hps_user_pkg::joystick_t      exp_joy0 = '0;
	hps_user_pkg::joystick_t      exp_joy1 = '0;
	hps_user_pkg::status_t        exp_status = '0;
	hps_user_pkg::stflg_t         exp_stflg = '0;
	hps_user_pkg::status_t        exp_req = '0;
	hps_user_pkg::ioctl_addr_t    wr_addr = '0;
	hps_user_pkg::ioctl_byte_t    wr_q [$];
	hps_user_pkg::ps2_byte_t      kbd_q [$];
	logic                         kbd_clk_prev = 1'b1;
	logic [10:0]                  rx_frame = '0;
	int                           rx_bits = 0;

	always #4 clk_sys = ~clk_sys;

	hps_io dut_i (
		.clk_sys            (clk_sys),
		.arst_n             (arst_n),
		.io_enable          (io_enable),
		.io_strobe          (io_strobe),
		.io_din             (io_din),
		.io_dout            (io_dout),
		.io_wait            (io_wait),
		.conf_str           (conf_str),
		.buttons            (buttons),
		.forced_scandoubler (forced_scandoubler),
		.joystick_0         (joystick_0),
		.joystick_1         (joystick_1),
		.status             (status),
		.status_in          (status_in),
		.status_set         (status_set),
		.ioctl_download     (ioctl_download),
		.ioctl_index        (ioctl_index),
		.ioctl_wr           (ioctl_wr),
		.ioctl_addr         (ioctl_addr),
		.ioctl_dout         (ioctl_dout),
		.ioctl_file_ext     (ioctl_file_ext),
		.ioctl_wait         (ioctl_wait),
		.ps2_kbd_clk_out    (ps2_kbd_clk_out),
		.ps2_kbd_data_out   (ps2_kbd_data_out)
	);

	////////////////////////////////////////////////////////////////////////////
	// random source and result checks

	// Galois form, taps 32,22,2,1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	task automatic rand_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			v = {v[30:0], lfsr[0]};
		end
	endtask

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("Errors found");
		$fatal(1);
	endtask

	task automatic check_joy(input string name, input hps_user_pkg::joystick_t exp, act);
		if (act !== exp)
			fail_run($sformatf("Mismatch %s: expected %h, actual %h", name, exp, act));
	endtask

	task automatic check_status(input string name, input hps_user_pkg::status_t exp, act);
		if (act !== exp)
			fail_run($sformatf("Mismatch %s: expected %h, actual %h", name, exp, act));
	endtask

	task automatic check_word(input string name, input hps_cmd_pkg::io_word_t exp, act);
		if (act !== exp)
			fail_run($sformatf("Mismatch %s: expected %h, actual %h", name, exp, act));
	endtask

	task automatic check_addr(input string name, input hps_user_pkg::ioctl_addr_t exp, act);
		if (act !== exp)
			fail_run($sformatf("Mismatch %s: expected %h, actual %h", name, exp, act));
	endtask

	task automatic check_byte(input string name, input hps_user_pkg::ioctl_byte_t exp, act);
		if (act !== exp)
			fail_run($sformatf("Mismatch %s: expected %h, actual %h", name, exp, act));
	endtask

	task automatic check_ext(input string name, input hps_user_pkg::file_ext_t exp, act);
		if (act !== exp)
			fail_run($sformatf("Mismatch %s: expected %h, actual %h", name, exp, act));
	endtask

	task automatic check_ps2(input string name, input hps_user_pkg::ps2_byte_t exp, act);
		if (act !== exp)
			fail_run($sformatf("Mismatch %s: expected %h, actual %h", name, exp, act));
	endtask

	task automatic check_buttons(input string name, input logic [1:0] exp, act);
		if (act !== exp)
			fail_run($sformatf("Mismatch %s: expected %h, actual %h", name, exp, act));
	endtask

	task automatic check_bit(input string name, input logic exp, act);
		if (act !== exp)
			fail_run($sformatf("Mismatch %s: expected %b, actual %b", name, exp, act));
	endtask

	////////////////////////////////////////////////////////////////////////////
	// host bus, one idle cycle between strobes

	task automatic run_frame(input hps_cmd_pkg::hps_cmd_e cmd, input int n_data);
		io_enable = 1'b1;
		for (int k = 0; k <= n_data; k++) begin
			while (io_wait)
				@(negedge clk_sys);
			io_strobe = 1'b1;
			if (k == 0)
				io_din = cmd;
			else
				io_din = data_buf[k];
			@(negedge clk_sys);
			io_strobe = 1'b0;
			reply_buf[k] = io_dout;
			@(negedge clk_sys);
		end
		io_enable = 1'b0;
		@(negedge clk_sys);
		@(negedge clk_sys);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// monitors

	always @(posedge clk_sys) begin
		cycles = cycles + 1;
		if (cycles > CYCLE_LIMIT)
			fail_run("run did not finish within the cycle limit");
	end

	// every write pulse takes the next byte at the next address
	always @(negedge clk_sys) begin
		if (ioctl_wr === 1'b1) begin
			if (wr_q.size() == 0) begin
				fail_run("ioctl_wr pulsed with no file data pending");
			end else begin
				check_bit("download during write", 1'b1, ioctl_download);
				check_addr("write address", wr_addr, ioctl_addr);
				check_byte("write data", wr_q.pop_front(), ioctl_dout);
				wr_addr = wr_addr + hps_user_pkg::ioctl_addr_t'(1);
			end
		end
	end

	// PS/2 device side, data sampled at falling clock edges
	always @(negedge clk_sys) begin
		if (kbd_clk_prev && !ps2_kbd_clk_out) begin
			rx_frame = {ps2_kbd_data_out, rx_frame[10:1]};
			rx_bits = rx_bits + 1;
			if (rx_bits == 11) begin
				rx_bits = 0;
				if (kbd_q.size() == 0) begin
					fail_run("keyboard byte sent that the host never pushed");
				end else begin
					check_bit("kbd start bit", 1'b0, rx_frame[0]);
					check_ps2("kbd byte", kbd_q.pop_front(), rx_frame[8:1]);
					check_bit("kbd parity", ~^rx_frame[8:1], rx_frame[9]);
					check_bit("kbd stop bit", 1'b1, rx_frame[10]);
				end
			end
		end
		kbd_clk_prev = ps2_kbd_clk_out;
	end

	////////////////////////////////////////////////////////////////////////////
	// tests

	task automatic test_regs();
		logic [31:0]           r;
		int                    n;
		hps_cmd_pkg::hps_cmd_e cmd;
		for (int f = 0; f < N_REG_FRAMES; f++) begin
			rand_bits(2, r);
			case (r[1:0])
				2'd0: cmd = hps_cmd_pkg::CMD_CFG;
				2'd1: cmd = hps_cmd_pkg::CMD_JOY0;
				2'd2: cmd = hps_cmd_pkg::CMD_JOY1;
				default: cmd = hps_cmd_pkg::CMD_STATUS;
			endcase
			rand_bits(1, r);
			n = (cmd == hps_cmd_pkg::CMD_CFG) ? 1 : (r[0] ? 2 : 1);
			if (cmd == hps_cmd_pkg::CMD_STATUS)
				n = 2;
			for (int k = 1; k <= n; k++) begin
				rand_bits(16, r);
				data_buf[k] = r[15:0];
			end
			run_frame(cmd, n);
			case (cmd)
				hps_cmd_pkg::CMD_CFG: begin
					exp_buttons = data_buf[1][1:0];
					exp_sd      = data_buf[1][`HPS_CFG_SCANDBL_BIT];
				end
				hps_cmd_pkg::CMD_JOY0: begin
					exp_joy0[15:0] = data_buf[1];
					if (n == 2)
						exp_joy0[31:16] = data_buf[2];
				end
				hps_cmd_pkg::CMD_JOY1: begin
					exp_joy1[15:0] = data_buf[1];
					if (n == 2)
						exp_joy1[31:16] = data_buf[2];
				end
				default: exp_status = {data_buf[2], data_buf[1]};
			endcase
			check_buttons("buttons", exp_buttons, buttons);
			check_bit("forced_scandoubler", exp_sd, forced_scandoubler);
			check_joy("joystick_0", exp_joy0, joystick_0);
			check_joy("joystick_1", exp_joy1, joystick_1);
			check_status("status", exp_status, status);
		end
	endtask

	task automatic test_conf_str();
		for (int k = 1; k <= `HPS_STRLEN + 2; k++)
			data_buf[k] = '0;
		run_frame(hps_cmd_pkg::CMD_CONF_STR, `HPS_STRLEN + 2);
		check_word("conf_str command reply", '0, reply_buf[0]);
		for (int k = 1; k <= `HPS_STRLEN + 2; k++) begin
			if (k <= `HPS_STRLEN)
				check_word($sformatf("conf_str word %0d", k), {8'h00, str_bytes[k]},
					reply_buf[k]);
			else
				check_word($sformatf("conf_str word %0d", k), '0, reply_buf[k]);
		end
		check_word("io_dout after frame", '0, io_dout);
	endtask

	task automatic test_status_set();
		logic [31:0] r;
		for (int p = 0; p < N_STATUS_PULSES; p++) begin
			rand_bits(3, r);
			repeat (r[2:0]) @(negedge clk_sys);
			rand_bits(32, r);
			status_in  = r;
			status_set = 1'b1;
			exp_req    = r;
			exp_stflg  = exp_stflg + hps_user_pkg::stflg_t'(1);
			rand_bits(1, r);
			@(negedge clk_sys);
			if (r[0])
				@(negedge clk_sys);
			status_set = 1'b0;
			// later values must not reach the captured request
			rand_bits(32, r);
			status_in = r;
			@(negedge clk_sys);
		end
		data_buf[1] = '0;
		data_buf[2] = '0;
		run_frame(hps_cmd_pkg::CMD_STATUS_SET, 2);
		check_word("status_set tag", hps_cmd_pkg::io_word_t'({`HPS_STATUS_SET_TAG, exp_stflg}),
			reply_buf[0]);
		check_word("status_set low half", exp_req[15:0], reply_buf[1]);
		check_word("status_set high half", exp_req[31:16], reply_buf[2]);
	endtask

	task automatic test_download();
		logic [31:0]               r;
		logic [7:0]                exp_index;
		hps_user_pkg::file_ext_t   exp_ext;
		rand_bits(16, r);
		data_buf[1] = r[15:0];
		exp_index   = r[7:0];
		run_frame(hps_cmd_pkg::CMD_FILE_INDEX, 1);
		rand_bits(32, r);
		exp_ext     = r;
		data_buf[1] = r[31:16];
		data_buf[2] = r[15:0];
		run_frame(hps_cmd_pkg::CMD_FILE_INFO, 2);
		rand_bits(16, r);
		data_buf[1] = r[15:0] | 16'h0001;
		wr_addr     = '0;
		run_frame(hps_cmd_pkg::CMD_FILE_TX, 1);
		check_bit("download after start", 1'b1, ioctl_download);
		// core busy, the host side has to see the wait
		ioctl_wait = 1'b1;
		@(negedge clk_sys);
		check_bit("io_wait while busy", 1'b1, io_wait);
		ioctl_wait = 1'b0;
		@(negedge clk_sys);
		check_bit("io_wait when ready", 1'b0, io_wait);
		for (int f = 0; f < N_DAT_FRAMES; f++) begin
			for (int k = 1; k <= DAT_BYTES; k++) begin
				rand_bits(16, r);
				data_buf[k] = r[15:0];
				wr_q.push_back(r[7:0]);
			end
			run_frame(hps_cmd_pkg::CMD_FILE_DAT, DAT_BYTES);
		end
		rand_bits(8, r);
		data_buf[1] = {r[7:0], 8'h00};
		run_frame(hps_cmd_pkg::CMD_FILE_TX, 1);
		if (wr_q.size() != 0)
			fail_run("file data was sent without a matching ioctl_wr pulse");
		check_bit("download after stop", 1'b0, ioctl_download);
		check_addr("address after stop", wr_addr, ioctl_addr);
		check_byte("ioctl_index", exp_index, ioctl_index);
		check_ext("ioctl_file_ext", exp_ext, ioctl_file_ext);
	endtask

	task automatic test_kbd();
		logic [31:0]           r;
		logic                  skip;
		hps_cmd_pkg::io_word_t w;
		for (int f = 0; f < N_KBD_FRAMES; f++) begin
			skip = 1'b0;
			for (int k = 1; k <= KBD_WORDS; k++) begin
				rand_bits(16, r);
				w = r[15:0];
				if (f == 1 && k == 2)
					w[15:8] = 8'hFF;
				data_buf[k] = w;
				if (!skip) begin
					if (w[15:8] == 8'hFF)
						skip = 1'b1;
					else
						kbd_q.push_back(w[7:0]);
				end
			end
			run_frame(hps_cmd_pkg::CMD_KBD, KBD_WORDS);
		end
		// let the transmitter drain, the cycle counter bounds this
		while (kbd_q.size() != 0 || rx_bits != 0)
			@(negedge clk_sys);
	endtask

	initial begin
		logic [31:0] r;
		arst_n     = 1'b0;
		io_enable  = 1'b0;
		io_strobe  = 1'b0;
		io_din     = '0;
		status_in  = '0;
		status_set = 1'b0;
		ioctl_wait = 1'b0;
		conf_str   = '0;
		// leftmost character first
		for (int i = 1; i <= `HPS_STRLEN; i++) begin
			rand_bits(8, r);
			str_bytes[i] = r[7:0];
			conf_str = {conf_str[8*`HPS_STRLEN-9:0], r[7:0]};
		end
		repeat (8) @(negedge clk_sys);
		arst_n = 1'b1;
		@(negedge clk_sys);

		check_word("io_dout after reset", '0, io_dout);
		check_bit("download after reset", 1'b0, ioctl_download);
		check_bit("ioctl_wr after reset", 1'b0, ioctl_wr);
		check_bit("ps2 clock after reset", 1'b1, ps2_kbd_clk_out);
		check_bit("ps2 data after reset", 1'b1, ps2_kbd_data_out);

		test_regs();
		test_conf_str();
		test_status_set();
		test_download();
		test_kbd();

		$display("No errors");
		$finish;
	end

endmodule

`default_nettype wire

// File: design/hps_cmd_frame.sv
// frame decoder: frame phase, command latch, data word index

`timescale 1ns/10ps
`default_nettype none

module hps_cmd_frame (
	input  wire logic                     clk_sys,
	input  wire logic                     arst_n,
	input  wire hps_cmd_pkg::hps_bus_in_t bus,
	output hps_cmd_pkg::cmd_beat_t        beat
);

	typedef enum logic [1:0] {
		FRAME_IDLE,
		FRAME_CMD,
		FRAME_DATA
	} frame_phase_e;

	frame_phase_e           phase;
	hps_cmd_pkg::hps_cmd_e  cmd_q;
	hps_cmd_pkg::word_idx_t next_idx;
	logic                   cmd_word;
	logic                   data_word;

	// the first strobe of a frame may come in the cycle enable rises
	assign cmd_word  = bus.enable && bus.strobe && (phase != FRAME_DATA);
	assign data_word = bus.enable && bus.strobe && (phase == FRAME_DATA);

	assign beat = '{
		cmd_word:  cmd_word,
		data_word: data_word,
		cmd:       cmd_word ? hps_cmd_pkg::hps_cmd_e'(bus.din) : cmd_q,
		idx:       cmd_word ? '0 : next_idx,
		din:       bus.din
	};

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			phase    <= FRAME_IDLE;
			next_idx <= '0;
		end else if (!bus.enable) begin
			phase <= FRAME_IDLE;
		end else if (cmd_word) begin
			phase    <= FRAME_DATA;
			next_idx <= hps_cmd_pkg::word_idx_t'(1);
		end else if (data_word) begin
			// long frames stick at the last index
			if (next_idx != '1)
				next_idx <= next_idx + hps_cmd_pkg::word_idx_t'(1);
		end else if (phase == FRAME_IDLE) begin
			phase <= FRAME_CMD;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (cmd_word)
			cmd_q <= hps_cmd_pkg::hps_cmd_e'(bus.din);
	end

	// data words are numbered from 1, even in long frames
	a_data_idx_nonzero : assert property (
		@(posedge clk_sys) disable iff (!arst_n) beat.data_word |-> (beat.idx != '0)
	);

endmodule

`default_nettype wire

// File: design/hps_cmd_pkg.sv
// host command port types: bus word, word index, command codes, bus input and decoded beat

`default_nettype none

`include "hps_defines.svh"

package hps_cmd_pkg;

	typedef logic [15:0] io_word_t;

	typedef logic [`HPS_IDX_BITS-1:0] word_idx_t;

	// command codes still served by the bridge
	typedef enum logic [15:0] {
		CMD_CFG        = 16'h0001,
		CMD_JOY0       = 16'h0002,
		CMD_JOY1       = 16'h0003,
		CMD_KBD        = 16'h0005,
		CMD_CONF_STR   = 16'h0014,
		CMD_STATUS     = 16'h001E,
		CMD_STATUS_SET = 16'h0029,
		CMD_FILE_TX    = 16'h0053,
		CMD_FILE_DAT   = 16'h0054,
		CMD_FILE_INDEX = 16'h0055,
		CMD_FILE_INFO  = 16'h0056
	} hps_cmd_e;

	typedef struct packed {
		logic     enable;
		logic     strobe;
		io_word_t din;
	} hps_bus_in_t;

	// one strobe, already sorted into command or data word
	typedef struct packed {
		logic      cmd_word;
		logic      data_word;
		hps_cmd_e  cmd;
		word_idx_t idx;
		io_word_t  din;
	} cmd_beat_t;

endpackage

`default_nettype wire

// File: design/hps_defines.svh
// shared macros: string length, PS/2 clock divider, keyboard FIFO depth, index width, field positions

`ifndef HPS_DEFINES_SVH
`define HPS_DEFINES_SVH

// length of the configuration string in bytes
`define HPS_STRLEN 8

// half period of the emulated PS/2 clock, in clk_sys cycles
`define HPS_PS2_DIV 4

// keyboard FIFO holds 2**HPS_PS2_FIFO_BITS bytes
`define HPS_PS2_FIFO_BITS 4

// width of the data word index within a frame
`define HPS_IDX_BITS 10

// returned next to the change counter on a STATUS_SET command word
`define HPS_STATUS_SET_TAG 4'hA

// configuration byte layout
// bits 1:0 are the buttons
`define HPS_CFG_SCANDBL_BIT 4

`endif

// File: design/hps_file_loader.sv
// file download: start/stop, index and extension, address counter, delayed write pulse

`timescale 1ns/10ps
`default_nettype none

module hps_file_loader (
	input  wire logic                   clk_sys,
	input  wire logic                   arst_n,
	input  wire hps_cmd_pkg::cmd_beat_t beat,
	output logic                        ioctl_download,
	output logic [7:0]                  ioctl_index,
	output logic                        ioctl_wr,
	output hps_user_pkg::ioctl_addr_t   ioctl_addr,
	output hps_user_pkg::ioctl_byte_t   ioctl_dout,
	output hps_user_pkg::file_ext_t     ioctl_file_ext
);

	hps_user_pkg::ioctl_addr_t addr;
	logic                      wr_q;
	logic                      tx_word;
	logic                      dat_word;
	logic                      tx_start;

	assign tx_word  = beat.data_word && (beat.cmd == hps_cmd_pkg::CMD_FILE_TX);
	assign dat_word = beat.data_word && (beat.cmd == hps_cmd_pkg::CMD_FILE_DAT);

	// nonzero low byte opens a download, zero closes it
	assign tx_start = |beat.din[7:0];

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			ioctl_download <= 1'b0;
			wr_q           <= 1'b0;
			ioctl_wr       <= 1'b0;
			addr           <= '0;
		end else begin
			// write pulse lags the data word by one more cycle
			wr_q     <= dat_word;
			ioctl_wr <= wr_q;

			if (tx_word) begin
				ioctl_download <= tx_start;
				if (tx_start)
					addr <= '0;
			end else if (dat_word) begin
				addr <= addr + hps_user_pkg::ioctl_addr_t'(1);
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		// stop leaves the final address on the port
		if (tx_word && !tx_start)
			ioctl_addr <= addr;

		if (dat_word) begin
			ioctl_addr <= addr;
			ioctl_dout <= beat.din[7:0];
		end

		if (beat.data_word) begin
			case (beat.cmd)
				hps_cmd_pkg::CMD_FILE_INDEX: ioctl_index <= beat.din[7:0];
				hps_cmd_pkg::CMD_FILE_INFO: begin
					// high half first
					if (beat.idx == hps_cmd_pkg::word_idx_t'(1))
						ioctl_file_ext[31:16] <= beat.din;
					else if (beat.idx == hps_cmd_pkg::word_idx_t'(2))
						ioctl_file_ext[15:0] <= beat.din;
				end
				default: begin
				end
			endcase
		end
	end

	a_wr_in_download : assert property (
		@(posedge clk_sys) disable iff (!arst_n) ioctl_wr |-> ioctl_download
	);

endmodule

`default_nettype wire

// File: design/hps_io.sv
// hps_io top: host bus packing, frame decoder, core registers, file loader, keyboard transmitter

`timescale 1ns/10ps
`default_nettype none

`include "hps_defines.svh"

module hps_io (
	input  wire logic                      clk_sys,
	input  wire logic                      arst_n,

	// host word bus
	input  wire logic                      io_enable,
	input  wire logic                      io_strobe,
	input  wire hps_cmd_pkg::io_word_t     io_din,
	output hps_cmd_pkg::io_word_t          io_dout,
	output logic                           io_wait,

	input  wire logic [8*`HPS_STRLEN-1:0]  conf_str,

	output logic [1:0]                     buttons,
	output logic                           forced_scandoubler,
	output hps_user_pkg::joystick_t        joystick_0,
	output hps_user_pkg::joystick_t        joystick_1,

	output hps_user_pkg::status_t          status,
	input  wire hps_user_pkg::status_t     status_in,
	input  wire logic                      status_set,

	// file download
	output logic                           ioctl_download,
	output logic [7:0]                     ioctl_index,
	output logic                           ioctl_wr,
	output hps_user_pkg::ioctl_addr_t      ioctl_addr,
	output hps_user_pkg::ioctl_byte_t      ioctl_dout,
	output hps_user_pkg::file_ext_t        ioctl_file_ext,
	input  wire logic                      ioctl_wait,

	// emulated PS/2 keyboard
	output logic                           ps2_kbd_clk_out,
	output logic                           ps2_kbd_data_out
);

	hps_cmd_pkg::hps_bus_in_t bus;
	hps_cmd_pkg::cmd_beat_t   beat;
	logic                     kbd_push;
	hps_user_pkg::ps2_byte_t  kbd_byte;

	assign bus = '{enable: io_enable, strobe: io_strobe, din: io_din};

	// host holds its strobes while the core is busy
	assign io_wait = ioctl_wait;

	hps_cmd_frame cmd_frame_i (
		.clk_sys (clk_sys),
		.arst_n  (arst_n),
		.bus     (bus),
		.beat    (beat)
	);

	hps_user_regs user_regs_i (
		.clk_sys            (clk_sys),
		.arst_n             (arst_n),
		.beat               (beat),
		.bus_enable         (io_enable),
		.conf_str           (conf_str),
		.status_in          (status_in),
		.status_set         (status_set),
		.io_dout            (io_dout),
		.buttons            (buttons),
		.forced_scandoubler (forced_scandoubler),
		.joystick_0         (joystick_0),
		.joystick_1         (joystick_1),
		.status             (status),
		.kbd_push           (kbd_push),
		.kbd_byte           (kbd_byte)
	);

	hps_file_loader file_loader_i (
		.clk_sys        (clk_sys),
		.arst_n         (arst_n),
		.beat           (beat),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.ioctl_file_ext (ioctl_file_ext)
	);

	ps2_kbd_tx kbd_tx_i (
		.clk_sys     (clk_sys),
		.arst_n      (arst_n),
		.push        (kbd_push),
		.push_byte   (kbd_byte),
		.ps2_clk_out (ps2_kbd_clk_out),
		.ps2_dat_out (ps2_kbd_data_out)
	);

endmodule

`default_nettype wire

// File: design/hps_user_pkg.sv
// core-facing types: joysticks, status, download fields, PS/2 byte, change counter, PS/2 TX states

`default_nettype none

package hps_user_pkg;

	typedef logic [31:0] joystick_t;

	typedef logic [31:0] status_t;

	// download side
	typedef logic [31:0] file_ext_t;
	typedef logic [26:0] ioctl_addr_t;
	typedef logic [7:0]  ioctl_byte_t;

	typedef logic [7:0] ps2_byte_t;

	// bumped on each status-set request from the core
	typedef logic [3:0] stflg_t;

	// what the data line carries after a PS/2 clock rise
	// TX_DATA covers the start bit and the eight data bits
	typedef enum logic [1:0] {
		TX_IDLE,
		TX_DATA,
		TX_PARITY,
		TX_STOP
	} ps2_tx_state_e;

endpackage

`default_nettype wire

// File: design/hps_user_regs.sv
// core registers: config, joysticks, status, status-set request, readback mux, keyboard push

`timescale 1ns/10ps
`default_nettype none

`include "hps_defines.svh"

module hps_user_regs (
	input  wire logic                     clk_sys,
	input  wire logic                     arst_n,
	input  wire hps_cmd_pkg::cmd_beat_t   beat,
	input  wire logic                     bus_enable,
	input  wire logic [8*`HPS_STRLEN-1:0] conf_str,
	input  wire hps_user_pkg::status_t    status_in,
	input  wire logic                     status_set,
	output hps_cmd_pkg::io_word_t         io_dout,
	output logic [1:0]                    buttons,
	output logic                          forced_scandoubler,
	output hps_user_pkg::joystick_t       joystick_0,
	output hps_user_pkg::joystick_t       joystick_1,
	output hps_user_pkg::status_t         status,
	output logic                          kbd_push,
	output hps_user_pkg::ps2_byte_t       kbd_byte
);

	logic                  status_set_q;
	logic                  status_req_new;
	hps_user_pkg::stflg_t  stflg;
	hps_user_pkg::status_t status_req;
	logic                  kbd_skip;
	logic                  kbd_word;
	logic                  kbd_take;
	logic                  first_half;
	hps_cmd_pkg::io_word_t reply;

	assign status_req_new = status_set && !status_set_q;

	// an all-ones upper byte ends the keyboard data of this frame
	assign kbd_word = beat.data_word && (beat.cmd == hps_cmd_pkg::CMD_KBD);
	assign kbd_take = kbd_word && !(&beat.din[15:8]) && !kbd_skip;

	assign first_half = (beat.idx == hps_cmd_pkg::word_idx_t'(1));

	////////////////////////////////////////////////////////////////////////////
	// host writes

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			buttons            <= '0;
			forced_scandoubler <= 1'b0;
			joystick_0         <= '0;
			joystick_1         <= '0;
			status             <= '0;
			kbd_push           <= 1'b0;
			kbd_skip           <= 1'b0;
		end else begin
			kbd_push <= kbd_take;
			if (!bus_enable)
				kbd_skip <= 1'b0;
			else if (kbd_word && (&beat.din[15:8]))
				kbd_skip <= 1'b1;

			if (beat.data_word) begin
				case (beat.cmd)
					hps_cmd_pkg::CMD_CFG: begin
						buttons            <= beat.din[1:0];
						forced_scandoubler <= beat.din[`HPS_CFG_SCANDBL_BIT];
					end
					hps_cmd_pkg::CMD_JOY0: begin
						if (first_half)
							joystick_0[15:0] <= beat.din;
						else
							joystick_0[31:16] <= beat.din;
					end
					hps_cmd_pkg::CMD_JOY1: begin
						if (first_half)
							joystick_1[15:0] <= beat.din;
						else
							joystick_1[31:16] <= beat.din;
					end
					hps_cmd_pkg::CMD_STATUS: begin
						if (first_half)
							status[15:0] <= beat.din;
						else if (beat.idx == hps_cmd_pkg::word_idx_t'(2))
							status[31:16] <= beat.din;
					end
					default: begin
					end
				endcase
			end
		end
	end

	// status-set request from the core, counted on its rising edge
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			status_set_q <= 1'b0;
			stflg        <= '0;
		end else begin
			status_set_q <= status_set;
			if (status_req_new)
				stflg <= stflg + hps_user_pkg::stflg_t'(1);
		end
	end

	always_ff @(posedge clk_sys) begin
		if (status_req_new)
			status_req <= status_in;
		if (kbd_take)
			kbd_byte <= beat.din[7:0];
	end

	////////////////////////////////////////////////////////////////////////////
	// readback, host picks it up at the next strobe

	always_comb begin
		reply = '0;
		if (beat.cmd_word) begin
			if (beat.cmd == hps_cmd_pkg::CMD_STATUS_SET)
				reply = hps_cmd_pkg::io_word_t'({`HPS_STATUS_SET_TAG, stflg});
		end else if (beat.data_word) begin
			case (beat.cmd)
				hps_cmd_pkg::CMD_STATUS_SET: begin
					if (first_half)
						reply = status_req[15:0];
					else if (beat.idx == hps_cmd_pkg::word_idx_t'(2))
						reply = status_req[31:16];
				end
				// byte 1 is the leftmost character
				hps_cmd_pkg::CMD_CONF_STR: begin
					for (int i = 1; i <= `HPS_STRLEN; i++) begin
						if (beat.idx == hps_cmd_pkg::word_idx_t'(i))
							reply = {8'h00, conf_str[(`HPS_STRLEN-i)*8 +: 8]};
					end
				end
				default: reply = '0;
			endcase
		end
	end

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n)
			io_dout <= '0;
		else if (!bus_enable)
			io_dout <= '0;
		else if (beat.cmd_word || beat.data_word)
			io_dout <= reply;
	end

endmodule

`default_nettype wire

// File: design/ps2_kbd_tx.sv
// PS/2 keyboard transmit: byte FIFO, PS/2 clock divider, serial transmitter

`timescale 1ns/10ps
`default_nettype none

`include "hps_defines.svh"

module ps2_kbd_tx (
	input  wire logic                    clk_sys,
	input  wire logic                    arst_n,
	input  wire logic                    push,
	input  wire hps_user_pkg::ps2_byte_t push_byte,
	output logic                         ps2_clk_out,
	output logic                         ps2_dat_out
);

	localparam int DEPTH = 1 << `HPS_PS2_FIFO_BITS;
	localparam int DIV_W = $clog2(`HPS_PS2_DIV);
	localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(`HPS_PS2_DIV - 1);

	// one extra bit tells full from empty
	typedef logic [`HPS_PS2_FIFO_BITS:0] fifo_ptr_t;

	hps_user_pkg::ps2_byte_t       fifo_mem [DEPTH];
	fifo_ptr_t                     wptr;
	fifo_ptr_t                     rptr;
	logic                          fifo_empty;
	logic                          fifo_full;
	logic [DIV_W-1:0]              div_cnt;
	logic                          clk_int;
	logic                          ps2_rise;
	logic                          ps2_fall;
	hps_user_pkg::ps2_tx_state_e   state;
	logic [3:0]                    bit_cnt;
	hps_user_pkg::ps2_byte_t       tx_shift;
	logic                          parity;

	////////////////////////////////////////////////////////////////////////////
	// byte FIFO

	assign fifo_empty = (wptr == rptr);
	assign fifo_full  = (wptr[`HPS_PS2_FIFO_BITS] != rptr[`HPS_PS2_FIFO_BITS]) &&
		(wptr[`HPS_PS2_FIFO_BITS-1:0] == rptr[`HPS_PS2_FIFO_BITS-1:0]);

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n)
			wptr <= '0;
		else if (push)
			wptr <= wptr + fifo_ptr_t'(1);
	end

	always_ff @(posedge clk_sys) begin
		if (push)
			fifo_mem[wptr[`HPS_PS2_FIFO_BITS-1:0]] <= push_byte;
	end

	////////////////////////////////////////////////////////////////////////////
	// PS/2 clock, toggles every HPS_PS2_DIV cycles

	assign ps2_rise = (div_cnt == DIV_LAST) && !clk_int;
	assign ps2_fall = (div_cnt == DIV_LAST) && clk_int;

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			div_cnt <= '0;
			clk_int <= 1'b0;
		end else if (div_cnt == DIV_LAST) begin
			div_cnt <= '0;
			clk_int <= ~clk_int;
		end else begin
			div_cnt <= div_cnt + DIV_W'(1);
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// transmitter, data changes on rises so the device samples on falls

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			state       <= hps_user_pkg::TX_IDLE;
			bit_cnt     <= '0;
			tx_shift    <= '0;
			parity      <= 1'b0;
			rptr        <= '0;
			ps2_dat_out <= 1'b1;
			ps2_clk_out <= 1'b1;
		end else begin
			// clock only pulses low while a byte is on its way
			if (ps2_fall)
				ps2_clk_out <= (state == hps_user_pkg::TX_IDLE);

			if (ps2_rise) begin
				ps2_clk_out <= 1'b1;
				case (state)
					hps_user_pkg::TX_IDLE: begin
						if (!fifo_empty) begin
							// start bit
							ps2_dat_out <= 1'b0;
							tx_shift    <= fifo_mem[rptr[`HPS_PS2_FIFO_BITS-1:0]];
							rptr        <= rptr + fifo_ptr_t'(1);
							parity      <= 1'b1;
							bit_cnt     <= '0;
							state       <= hps_user_pkg::TX_DATA;
						end
					end
					hps_user_pkg::TX_DATA: begin
						if (bit_cnt == 4'd8) begin
							ps2_dat_out <= parity;
							state       <= hps_user_pkg::TX_PARITY;
						end else begin
							// LSB first, parity kept odd
							ps2_dat_out <= tx_shift[0];
							tx_shift    <= tx_shift >> 1;
							parity      <= parity ^ tx_shift[0];
							bit_cnt     <= bit_cnt + 4'd1;
						end
					end
					hps_user_pkg::TX_PARITY: begin
						ps2_dat_out <= 1'b1;
						state       <= hps_user_pkg::TX_STOP;
					end
					default: state <= hps_user_pkg::TX_IDLE;
				endcase
			end
		end
	end

	a_no_overflow : assert property (
		@(posedge clk_sys) disable iff (!arst_n) push |-> !fifo_full
	);

	a_idle_line_high : assert property (
		@(posedge clk_sys) disable iff (!arst_n)
			(state == hps_user_pkg::TX_IDLE) |-> ps2_dat_out
	);

endmodule

`default_nettype wire

// File: sources.f
+incdir+design
design/hps_cmd_pkg.sv
design/hps_user_pkg.sv
design/hps_cmd_frame.sv
design/hps_user_regs.sv
design/hps_file_loader.sv
design/ps2_kbd_tx.sv
design/hps_io.sv
bench/tb_hps_io.sv
